/* src/rv_pkg.sv */
package rv_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // execution commands seen by exec_unit
    typedef enum logic [3:0] {
        cmd_nop  = 4'd0,
        cmd_add  = 4'd1,
        cmd_pass = 4'd2, // forwards src2, used by lui
        cmd_halt = 4'd3
    } exu_cmd_t;

    typedef enum logic [2:0] {
        imm_none = 3'd0,
        imm_i    = 3'd1,
        imm_u    = 3'd2
    } imm_fmt_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    // the only system encoding the core accepts
    localparam logic [xlen-1:0] inst_ebreak = 32'h0010_0073;

    // decode to execute, 74 bits
    typedef struct packed {
        exu_cmd_t                  cmd;
        logic [xlen-1:0]           src1;
        logic [xlen-1:0]           src2;
        logic [reg_addr_width-1:0] rd;
        logic                      wr_en;
    } decoded_op_t;

endpackage

/* src/fetch_pc.sv */
`timescale 1ns/100ps

module fetch_pc #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = rv_pkg::reset_pc
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    halt_req,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic                    halted
);

    logic [rv_pkg::xlen-1:0] pc_next;

    assign pc_next = pc + rv_pkg::xlen'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else begin
            // sticky until reset
            if (halt_req) begin
                halted <= 1'b1;
            end
            if (!halted) begin
                pc <= pc_next; // ebreak edge still steps
            end
        end
    end

endmodule

/* src/inst_decode.sv */
`timescale 1ns/100ps

module inst_decode (
    input  logic [rv_pkg::xlen-1:0]           inst,
    input  logic [rv_pkg::xlen-1:0]           pc,
    input  logic [rv_pkg::xlen-1:0]           rdata1,
    input  logic [rv_pkg::xlen-1:0]           rdata2,
    output logic [rv_pkg::reg_addr_width-1:0] raddr1,
    output logic [rv_pkg::reg_addr_width-1:0] raddr2,
    output rv_pkg::decoded_op_t               op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [rv_pkg::reg_addr_width-1:0] rs1;
    logic [rv_pkg::reg_addr_width-1:0] rs2;
    logic [rv_pkg::reg_addr_width-1:0] rd;

    rv_pkg::imm_fmt_t imm_fmt;
    logic [rv_pkg::xlen-1:0] imm;

    logic rd1_en;
    logic rd2_en;
    logic wr_en;
    rv_pkg::exu_cmd_t cmd;
    logic [rv_pkg::xlen-1:0] src1;
    logic [rv_pkg::xlen-1:0] src2;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    // immediate format follows the opcode alone
    always_comb begin
        case (opcode)
            rv_pkg::op_imm:   imm_fmt = rv_pkg::imm_i;
            rv_pkg::op_lui,
            rv_pkg::op_auipc: imm_fmt = rv_pkg::imm_u;
            default:          imm_fmt = rv_pkg::imm_none;
        endcase
    end

    always_comb begin
        case (imm_fmt)
            rv_pkg::imm_i: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::imm_u: imm = {inst[31:12], 12'b0};
            default:       imm = '0;
        endcase
    end

    always_comb begin
        // nop unless an opcode below says otherwise
        cmd    = rv_pkg::cmd_nop;
        src1   = '0;
        src2   = '0;
        rd1_en = 1'b0;
        rd2_en = 1'b0;
        wr_en  = 1'b0;
        case (opcode)
            rv_pkg::op_imm: begin // addi
                cmd    = rv_pkg::cmd_add;
                src1   = imm;
                src2   = rdata1;
                rd1_en = 1'b1;
                wr_en  = 1'b1;
            end
            rv_pkg::op_reg: begin
                if (funct3 == 3'b000 && funct7 == 7'b0) begin // add only
                    cmd    = rv_pkg::cmd_add;
                    src1   = rdata1;
                    src2   = rdata2;
                    rd1_en = 1'b1;
                    rd2_en = 1'b1;
                    wr_en  = 1'b1;
                end
            end
            rv_pkg::op_lui: begin
                cmd   = rv_pkg::cmd_pass;
                src2  = imm;
                wr_en = 1'b1;
            end
            rv_pkg::op_auipc: begin
                cmd   = rv_pkg::cmd_add;
                src1  = pc;
                src2  = imm;
                wr_en = 1'b1;
            end
            rv_pkg::op_system: begin
                if (inst == rv_pkg::inst_ebreak) begin
                    cmd = rv_pkg::cmd_halt;
                end
            end
            default: ;
        endcase
    end

    // unused fields never reach the register file
    assign raddr1 = rd1_en ? rs1 : '0;
    assign raddr2 = rd2_en ? rs2 : '0;

    assign op.cmd   = cmd;
    assign op.src1  = src1;
    assign op.src2  = src2;
    assign op.rd    = wr_en ? rd : '0;
    assign op.wr_en = wr_en;

endmodule

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
    parameter int num_regs = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wr_en,
    input  logic [rv_pkg::reg_addr_width-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]           wdata,
    input  logic [rv_pkg::reg_addr_width-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_width-1:0] raddr2,
    output logic [rv_pkg::xlen-1:0]           rdata1,
    output logic [rv_pkg::xlen-1:0]           rdata2
);

    logic [rv_pkg::xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && waddr != '0) begin // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // read before write within a cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* src/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit (
    input  rv_pkg::decoded_op_t               op,
    input  logic                              halted,
    input  logic                              rst,
    output logic                              wb_en,
    output logic [rv_pkg::reg_addr_width-1:0] wb_addr,
    output logic [rv_pkg::xlen-1:0]           wb_data,
    output logic                              halt_req
);

    logic [rv_pkg::xlen-1:0] sum;

    assign sum = op.src1 + op.src2; // wraps mod 2^32

    always_comb begin
        case (op.cmd)
            rv_pkg::cmd_add:  wb_data = sum;
            rv_pkg::cmd_pass: wb_data = op.src2;
            default:          wb_data = '0;
        endcase
    end

    // nothing retires after ebreak or in reset
    assign wb_en    = op.wr_en & ~halted & ~rst;
    assign wb_addr  = op.rd;
    assign halt_req = (op.cmd == rv_pkg::cmd_halt);

endmodule

/* src/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = rv_pkg::reset_pc,
    parameter int                      num_regs = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [rv_pkg::xlen-1:0]           inst,
    output logic [rv_pkg::xlen-1:0]           pc,
    output logic                              halted,
    output logic                              wb_en,
    output logic [rv_pkg::reg_addr_width-1:0] wb_addr,
    output logic [rv_pkg::xlen-1:0]           wb_data
);

    logic [rv_pkg::reg_addr_width-1:0] raddr1;
    logic [rv_pkg::reg_addr_width-1:0] raddr2;
    logic [rv_pkg::xlen-1:0] rdata1;
    logic [rv_pkg::xlen-1:0] rdata2;
    rv_pkg::decoded_op_t op;
    logic halt_req;

    fetch_pc #(
        .reset_pc(reset_pc)
    ) i_fetch (
        .clk     (clk),
        .rst     (rst),
        .halt_req(halt_req),
        .pc      (pc),
        .halted  (halted)
    );

    inst_decode i_decode (
        .inst  (inst),
        .pc    (pc),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .raddr1(raddr1),
        .raddr2(raddr2),
        .op    (op)
    );

    reg_file #(
        .num_regs(num_regs)
    ) i_regs (
        .clk   (clk),
        .rst   (rst),
        .wr_en (wb_en), // writeback port
        .waddr (wb_addr),
        .wdata (wb_data),
        .raddr1(raddr1),
        .raddr2(raddr2),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    exec_unit i_exec (
        .op      (op),
        .halted  (halted),
        .rst     (rst),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .halt_req(halt_req)
    );

endmodule

/* test/rv_core_assertions.sv */
`timescale 1ns/100ps

module rv_core_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic [rv_pkg::xlen-1:0] pc,
    input logic                    halted,
    input logic                    wb_en
);

    int unsigned fail_count = 0; // read by the testbench at the end

    // only reset clears halted
    halted_sticky: assert property (@(posedge clk) halted && !rst |=> halted)
        else begin
            fail_count++;
            $error("halted dropped without reset");
        end

    pc_step: assert property (@(posedge clk) !rst && !halted |=> pc == $past(pc) + 32'd4)
        else begin
            fail_count++;
            $error("pc did not step by four");
        end

    pc_hold: assert property (@(posedge clk) !rst && halted |=> pc == $past(pc))
        else begin
            fail_count++;
            $error("pc moved while halted");
        end

    // nothing retires in reset or after ebreak
    no_wb_idle: assert property (@(posedge clk) !(wb_en && (rst || halted)))
        else begin
            fail_count++;
            $error("writeback during reset or halt");
        end

endmodule

/* test/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;

    localparam int body_len    = 300;
    localparam int tail_len    = 10; // random words after ebreak
    localparam int prog_len    = body_len + 1 + tail_len;
    localparam int cycle_limit = prog_len + 50;

    logic                              clk;
    logic                              rst;
    logic [rv_pkg::xlen-1:0]           inst;
    logic [rv_pkg::xlen-1:0]           pc;
    logic                              halted;
    logic                              wb_en;
    logic [rv_pkg::reg_addr_width-1:0] wb_addr;
    logic [rv_pkg::xlen-1:0]           wb_data;

    logic [31:0] prog [prog_len];
    logic [31:0] lfsr_state = 32'd15543;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;

    // reference model state
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic        model_halted;
    logic        exp_wr;
    logic [4:0]  exp_addr;
    logic [31:0] exp_data;
    logic        exp_halt;

    rv_core #(
        .reset_pc(32'h8000_0000),
        .num_regs(32)
    ) i_dut (
        .clk    (clk),
        .rst    (rst),
        .inst   (inst),
        .pc     (pc),
        .halted (halted),
        .wb_en  (wb_en),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

    bind rv_core rv_core_assertions i_assertions (
        .clk   (clk),
        .rst   (rst),
        .pc    (pc),
        .halted(halted),
        .wb_en (wb_en)
    );

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, rv_pkg::op_imm};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic build_program();
        logic [2:0] kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int i = 0; i < prog_len; i++) begin
            kind = 3'(rand_bits(3));
            rd   = 5'(rand_bits(3)); // x0..x7 so results get reused
            rs1  = 5'(rand_bits(3));
            rs2  = 5'(rand_bits(3));
            if (i == body_len) begin
                prog[i] = 32'h0010_0073; // ebreak
            end else begin
                case (kind)
                    3'd0, 3'd1: prog[i] = enc_i(12'(rand_bits(12)), rs1, rd);
                    3'd2: prog[i] = enc_r(7'd0, rs2, rs1, 3'd0, rd);
                    3'd3: prog[i] = enc_u(20'(rand_bits(20)), rd, rv_pkg::op_lui);
                    3'd4: prog[i] = enc_u(20'(rand_bits(20)), rd, rv_pkg::op_auipc);
                    3'd5: prog[i] = enc_i(12'(rand_bits(12)), rs1, 5'd0); // x0 target
                    3'd6: prog[i] = enc_r(7'(rand_bits(7)), rs2, rs1, 3'(rand_bits(3)), rd);
                    default: prog[i] = rand_bits(32); // mostly unknown opcodes
                endcase
            end
        end
    endtask

    task automatic predict(input logic [31:0] word);
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        opc   = word[6:0];
        rd    = word[11:7];
        rs1   = word[19:15];
        rs2   = word[24:20];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_u = {word[31:12], 12'h000};
        exp_wr   = 1'b0;
        exp_data = '0;
        exp_halt = 1'b0;
        if (opc == rv_pkg::op_imm) begin
            exp_wr   = 1'b1;
            exp_data = model_regs[rs1] + imm_i;
        end else if (opc == rv_pkg::op_reg && word[31:25] == 7'd0 && word[14:12] == 3'd0) begin
            exp_wr   = 1'b1;
            exp_data = model_regs[rs1] + model_regs[rs2];
        end else if (opc == rv_pkg::op_lui) begin
            exp_wr   = 1'b1;
            exp_data = imm_u;
        end else if (opc == rv_pkg::op_auipc) begin
            exp_wr   = 1'b1;
            exp_data = model_pc + imm_u;
        end else if (word == 32'h0010_0073) begin
            exp_halt = 1'b1;
        end
        exp_addr = exp_wr ? rd : 5'd0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic final_report();
        int unsigned assert_fails;
        assert_fails = i_dut.i_assertions.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d, cycles %0d",
                 checks, errors, assert_fails, cycle_count);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            errors++;
            final_report();
        end
    end

    initial begin
        clk  = 1'b0;
        rst  = 1'b1;
        inst = enc_i(12'd5, 5'd0, 5'd1); // would write x1 if not in reset
        build_program();
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        model_pc     = 32'h8000_0000;
        model_halted = 1'b0;

        @(negedge clk);
        #2;
        check_value("wb_en in reset", 32'd0, 32'(wb_en));
        @(negedge clk);
        rst = 1'b0;
        check_value("pc after reset", 32'h8000_0000, pc);
        check_value("halted after reset", 32'd0, 32'(halted));

        for (int i = 0; i < prog_len; i++) begin
            inst = prog[i];
            #2;
            predict(prog[i]);
            check_value($sformatf("pc %0d", i), model_pc, pc);
            check_value($sformatf("halted %0d", i), 32'(model_halted), 32'(halted));
            check_value($sformatf("wb_en %0d", i), 32'(exp_wr & ~model_halted), 32'(wb_en));
            check_value($sformatf("wb_addr %0d", i), 32'(exp_addr), 32'(wb_addr));
            if (exp_wr && !model_halted) begin
                check_value($sformatf("wb_data %0d", i), exp_data, wb_data);
            end
            @(posedge clk);
            if (exp_wr && !model_halted && exp_addr != 5'd0) begin
                model_regs[exp_addr] = exp_data;
            end
            if (!model_halted) begin
                model_pc = model_pc + 32'd4;
            end
            if (exp_halt) begin
                model_halted = 1'b1;
            end
            @(negedge clk);
        end
        final_report();
    end

endmodule

/* project.f */
src/rv_pkg.sv
src/fetch_pc.sv
src/inst_decode.sv
src/reg_file.sv
src/exec_unit.sv
src/rv_core.sv
test/rv_core_assertions.sv
test/tb_rv_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f project.f

out=$(./obj_dir/Vtb_rv_core) || true
printf '%s\n' "$out"

# pass only when the testbench printed the pass line
printf '%s\n' "$out" | grep -qx 'TEST PASSED'
